/* logic/battleship_pkg.sv */
// Sizes are fixed for a 10 by 10 board and a five ship fleet and result codes travel in the serial frame
package battleship_pkg;

    // ------------------------------
    // Board and fleet
    // ------------------------------
    localparam int BOARD_SIZE = 10;
    localparam int COORD_W    = 4;
    localparam int NUM_SHIPS  = 5;
    localparam int SHIP_ID_W  = 3;
    localparam int SHIP_LEN_W = 3;

    // Length of each ship by index, placed in this order
    localparam logic [SHIP_LEN_W-1:0] SHIP_LENGTHS [NUM_SHIPS] = '{
        3'd5,
        3'd4,
        3'd3,
        3'd3,
        3'd2
    };

    // ------------------------------
    // Serial frame
    // ------------------------------
    // MSB first: code(3) player(1) row(4) col(4) ship(3) game_over(1)
    localparam int FRAME_W = 16;

    // ------------------------------
    // Shared encodings
    // ------------------------------
    typedef enum logic [1:0] {
        cell_empty = 2'b00,
        cell_ship  = 2'b01,
        cell_miss  = 2'b10,
        cell_hit   = 2'b11
    } cell_state_t;

    typedef enum logic [2:0] {
        res_placed   = 3'd0,
        res_rejected = 3'd1,
        res_miss     = 3'd2,
        res_hit      = 3'd3,
        res_sunk     = 3'd4,
        res_win      = 3'd5,
        res_repeat   = 3'd6
    } result_t;

endpackage

/* logic/result_serializer.sv */
// Each frame takes 32 system clocks and the half period counter assumes FRAME_W is a power of two
`timescale 1ns/1ps

module result_serializer (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               frame_load,
    input  logic [battleship_pkg::FRAME_W-1:0] frame,
    output logic                               serializer_busy,
    output logic                               sclk,
    output logic                               sdo
);
    import battleship_pkg::*;

    logic [FRAME_W-1:0]           shreg;
    logic [$clog2(2*FRAME_W)-1:0] half_cnt;

    // MSB drives the line while sclk is low and zeros fill in behind
    assign sdo = shreg[FRAME_W-1];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            serializer_busy <= 1'b0;
            sclk            <= 1'b0;
            shreg           <= '0;
            half_cnt        <= '0;
        end
        else if (frame_load)
        begin
            serializer_busy <= 1'b1;
            sclk            <= 1'b0;
            shreg           <= frame;
            half_cnt        <= '0;
        end
        else if (serializer_busy)
        begin
            sclk     <= !sclk;
            half_cnt <= half_cnt + 1'b1;
            // Next bit moves up on the falling edge of sclk
            if (sclk)
                shreg <= {shreg[FRAME_W-2:0], 1'b0};
            // Counter full means the 16th falling edge
            if (&half_cnt)
                serializer_busy <= 1'b0;
        end
    end

    a_load_when_idle: assert property (@(posedge clk) disable iff (reset)
        frame_load |-> !serializer_busy)
        else $error("frame load while serializer busy");

endmodule

/* logic/fleet_tracker.sv */
// Holds one finished result at a time and stalls the board engine while the serializer is busy
`timescale 1ns/1ps

module fleet_tracker (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 event_valid,
    input  battleship_pkg::result_t              event_code,
    input  logic                                 event_player,
    input  logic [battleship_pkg::COORD_W-1:0]   event_row,
    input  logic [battleship_pkg::COORD_W-1:0]   event_col,
    input  logic [battleship_pkg::SHIP_ID_W-1:0] event_ship,
    input  logic                                 serializer_busy,
    output logic                                 tracker_hold,
    output logic                                 game_over,
    output logic                                 result_valid,
    output battleship_pkg::result_t              result,
    output logic                                 frame_load,
    output logic [battleship_pkg::FRAME_W-1:0]   frame
);
    import battleship_pkg::*;

    logic [SHIP_LEN_W-1:0] remaining [2][NUM_SHIPS];
    logic [SHIP_ID_W-1:0]  afloat    [2];
    logic                  pending;
    result_t               pend_code;
    logic [FRAME_W-1:0]    pend_frame;

    logic                  opponent;
    logic                  emit;
    logic                  consume;
    logic                  last_cell;
    logic                  last_ship;
    result_t               next_code;
    logic                  next_over;

    assign opponent     = !event_player;
    // Frame goes out once the serializer is free and not just loaded
    assign emit         = pending && !serializer_busy && !frame_load;
    assign tracker_hold = pending && !emit;
    assign consume      = event_valid && !tracker_hold;

    assign last_cell = (remaining[opponent][event_ship] == SHIP_LEN_W'(1));
    assign last_ship = (afloat[opponent] == SHIP_ID_W'(1));

    // Promote a hit on the last cell to sunk or win
    always_comb
    begin
        next_code = event_code;
        next_over = game_over;
        if ((event_code == res_hit) && last_cell)
        begin
            next_code = last_ship ? res_win : res_sunk;
            next_over = game_over || last_ship;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pending      <= 1'b0;
            game_over    <= 1'b0;
            result_valid <= 1'b0;
            frame_load   <= 1'b0;
            afloat[0]    <= '0;
            afloat[1]    <= '0;
        end
        else
        begin
            result_valid <= emit;
            frame_load   <= emit;
            if (emit)
                pending <= 1'b0;
            if (consume)
            begin
                pending   <= 1'b1;
                game_over <= next_over;
                if (event_code == res_placed)
                    afloat[event_player] <= afloat[event_player] + 1'b1;
                else if ((event_code == res_hit) && last_cell)
                    afloat[opponent] <= afloat[opponent] - 1'b1;
            end
        end
    end

    // ------------------------------
    // Ship counts and result hold
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (consume)
        begin
            pend_code  <= next_code;
            pend_frame <= {next_code, event_player, event_row, event_col,
                           event_ship, next_over};
            if (event_code == res_placed)
                remaining[event_player][event_ship] <= SHIP_LENGTHS[event_ship];
            else if (event_code == res_hit)
                remaining[opponent][event_ship] <= remaining[opponent][event_ship] - 1'b1;
        end
        if (emit)
        begin
            result <= pend_code;
            frame  <= pend_frame;
        end
    end

    // Engine only reports hits on cells still marked as ship
    a_hit_live_ship: assert property (@(posedge clk) disable iff (reset)
        (consume && (event_code == res_hit)) |-> (remaining[opponent][event_ship] != '0))
        else $error("hit on a ship with no cells left");

endmodule

/* logic/board_engine.sv */
// Moves that arrive while busy are dropped and no turn order is enforced between the players
`timescale 1ns/1ps

module board_engine (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 move_strobe,
    input  logic                                 player,
    input  logic                                 horizontal,
    input  logic [battleship_pkg::COORD_W-1:0]   row,
    input  logic [battleship_pkg::COORD_W-1:0]   col,
    input  logic                                 tracker_hold,
    input  logic                                 game_over,
    output logic                                 busy,
    output logic                                 event_valid,
    output battleship_pkg::result_t              event_code,
    output logic                                 event_player,
    output logic [battleship_pkg::COORD_W-1:0]   event_row,
    output logic [battleship_pkg::COORD_W-1:0]   event_col,
    output logic [battleship_pkg::SHIP_ID_W-1:0] event_ship
);
    import battleship_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_check,
        st_scan,
        st_write,
        st_shot_read,
        st_shot_write,
        st_report
    } state_t;

    state_t                state;

    // Accepted move
    logic                  mv_player;
    logic                  mv_horizontal;
    logic [COORD_W-1:0]    mv_row;
    logic [COORD_W-1:0]    mv_col;

    logic [SHIP_ID_W-1:0]  placed_cnt [2];
    logic [SHIP_LEN_W-1:0] step;

    cell_state_t           board    [2][BOARD_SIZE][BOARD_SIZE];
    logic [SHIP_ID_W-1:0]  ship_map [2][BOARD_SIZE][BOARD_SIZE];
    cell_state_t           shot_cell;
    logic [SHIP_ID_W-1:0]  shot_ship;

    logic [SHIP_ID_W-1:0]  ship_idx;
    logic                  fleet_full;
    logic                  placing;
    logic [SHIP_LEN_W-1:0] ship_len;
    logic [COORD_W:0]      end_pos;
    logic                  reject;
    logic [COORD_W-1:0]    cur_row;
    logic [COORD_W-1:0]    cur_col;
    logic                  rd_player;
    cell_state_t           rd_cell;
    logic                  board_we;
    logic                  wr_player;
    cell_state_t           wr_cell;

    // ------------------------------
    // Move checks
    // ------------------------------
    assign ship_idx   = placed_cnt[mv_player];
    assign fleet_full = (ship_idx == SHIP_ID_W'(NUM_SHIPS));
    assign placing    = !((placed_cnt[0] == SHIP_ID_W'(NUM_SHIPS)) &&
                          (placed_cnt[1] == SHIP_ID_W'(NUM_SHIPS)));
    assign ship_len   = fleet_full ? '0 : SHIP_LENGTHS[ship_idx];

    // Last cell along the ship axis is one bit wider so it cannot wrap
    assign end_pos = (mv_horizontal ? {1'b0, mv_col} : {1'b0, mv_row})
                     + (COORD_W + 1)'(ship_len) - 1'b1;

    assign reject = game_over
                    || (mv_row >= COORD_W'(BOARD_SIZE))
                    || (mv_col >= COORD_W'(BOARD_SIZE))
                    || (placing && (fleet_full || end_pos >= (COORD_W + 1)'(BOARD_SIZE)));

    // Step walks along the ship and stays zero for shots
    assign cur_row = mv_horizontal ? mv_row : mv_row + COORD_W'(step);
    assign cur_col = mv_horizontal ? mv_col + COORD_W'(step) : mv_col;

    // Placements touch the own board, shots the opponent's
    assign rd_player = (state == st_scan) ? mv_player : !mv_player;
    assign rd_cell   = board[rd_player][cur_row][cur_col];

    assign board_we  = (state == st_write) ||
                       ((state == st_shot_write) &&
                        ((shot_cell == cell_ship) || (shot_cell == cell_empty)));
    assign wr_player = (state == st_write) ? mv_player : !mv_player;
    assign wr_cell   = (state == st_write)       ? cell_ship :
                       (shot_cell == cell_ship)  ? cell_hit  : cell_miss;

    assign busy         = (state != st_idle);
    assign event_valid  = (state == st_report);
    assign event_player = mv_player;
    assign event_row    = mv_row;
    assign event_col    = mv_col;

    // ------------------------------
    // Control FSM
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state         <= st_idle;
            placed_cnt[0] <= '0;
            placed_cnt[1] <= '0;
            step          <= '0;
            event_code    <= res_rejected;
            event_ship    <= '0;
        end
        else
        begin
            case (state)
                st_idle:
                    if (move_strobe)
                        state <= st_check;
                st_check:
                begin
                    step       <= '0;
                    event_ship <= '0;
                    if (reject)
                    begin
                        event_code <= res_rejected;
                        state      <= st_report;
                    end
                    else if (placing)
                    begin
                        event_ship <= ship_idx;
                        state      <= st_scan;
                    end
                    else
                        state <= st_shot_read;
                end
                st_scan:
                    if (rd_cell != cell_empty)
                    begin
                        event_code <= res_rejected;
                        event_ship <= '0;
                        state      <= st_report;
                    end
                    else if (step == ship_len - 1'b1)
                    begin
                        step  <= '0;
                        state <= st_write;
                    end
                    else
                        step <= step + 1'b1;
                st_write:
                    if (step == ship_len - 1'b1)
                    begin
                        event_code            <= res_placed;
                        placed_cnt[mv_player] <= placed_cnt[mv_player] + 1'b1;
                        state                 <= st_report;
                    end
                    else
                        step <= step + 1'b1;
                st_shot_read:
                    state <= st_shot_write;
                st_shot_write:
                begin
                    state <= st_report;
                    case (shot_cell)
                        cell_ship:
                        begin
                            event_code <= res_hit;
                            event_ship <= shot_ship;
                        end
                        cell_empty:
                            event_code <= res_miss;
                        default:
                            event_code <= res_repeat;
                    endcase
                end
                st_report:
                    if (!tracker_hold)
                        state <= st_idle;
                default:
                    state <= st_idle;
            endcase
        end
    end

    // Move and shot capture
    always_ff @(posedge clk)
    begin
        if ((state == st_idle) && move_strobe)
        begin
            mv_player     <= player;
            mv_horizontal <= horizontal;
            mv_row        <= row;
            mv_col        <= col;
        end
        if (state == st_shot_read)
        begin
            shot_cell <= rd_cell;
            shot_ship <= ship_map[!mv_player][cur_row][cur_col];
        end
    end

    // ------------------------------
    // Boards
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int p = 0; p < 2; p++)
                for (int r = 0; r < BOARD_SIZE; r++)
                    for (int c = 0; c < BOARD_SIZE; c++)
                        board[p][r][c] <= cell_empty;
        end
        else if (board_we)
            board[wr_player][cur_row][cur_col] <= wr_cell;
    end

    always_ff @(posedge clk)
    begin
        if (state == st_write)
            ship_map[mv_player][cur_row][cur_col] <= ship_idx;
    end

    // Every write lands on a cell of the board
    a_write_in_board: assert property (@(posedge clk) disable iff (reset)
        board_we |-> (cur_row < COORD_W'(BOARD_SIZE)) && (cur_col < COORD_W'(BOARD_SIZE)))
        else $error("board write outside the board");

    // Tracker back-pressure must freeze the whole event
    a_event_stable: assert property (@(posedge clk) disable iff (reset)
        (event_valid && tracker_hold) |=> event_valid && $stable(event_code)
            && $stable(event_ship) && $stable(event_player)
            && $stable(event_row) && $stable(event_col))
        else $error("event changed while tracker held it");

endmodule

/* logic/battleship_top.sv */
// Two player game core with no turn order and results reported in move acceptance order
`timescale 1ns/1ps

module battleship_top (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               move_strobe,
    input  logic                               player,
    input  logic                               horizontal,
    input  logic [battleship_pkg::COORD_W-1:0] row,
    input  logic [battleship_pkg::COORD_W-1:0] col,
    output logic                               busy,
    output logic                               result_valid,
    output logic                               game_over,
    output logic                               sclk,
    output logic                               sdo,
    output battleship_pkg::result_t            result
);
    import battleship_pkg::*;

    // Engine to tracker
    logic                 event_valid;
    result_t              event_code;
    logic                 event_player;
    logic [COORD_W-1:0]   event_row;
    logic [COORD_W-1:0]   event_col;
    logic [SHIP_ID_W-1:0] event_ship;
    logic                 tracker_hold;

    // Tracker to serializer
    logic                 frame_load;
    logic [FRAME_W-1:0]   frame;
    logic                 serializer_busy;

    board_engine u_engine (
        .clk          (clk),
        .reset        (reset),
        .move_strobe  (move_strobe),
        .player       (player),
        .horizontal   (horizontal),
        .row          (row),
        .col          (col),
        .tracker_hold (tracker_hold),
        .game_over    (game_over),
        .busy         (busy),
        .event_valid  (event_valid),
        .event_code   (event_code),
        .event_player (event_player),
        .event_row    (event_row),
        .event_col    (event_col),
        .event_ship   (event_ship)
    );

    fleet_tracker u_tracker (
        .clk             (clk),
        .reset           (reset),
        .event_valid     (event_valid),
        .event_code      (event_code),
        .event_player    (event_player),
        .event_row       (event_row),
        .event_col       (event_col),
        .event_ship      (event_ship),
        .serializer_busy (serializer_busy),
        .tracker_hold    (tracker_hold),
        .game_over       (game_over),
        .result_valid    (result_valid),
        .result          (result),
        .frame_load      (frame_load),
        .frame           (frame)
    );

    result_serializer u_serializer (
        .clk             (clk),
        .reset           (reset),
        .frame_load      (frame_load),
        .frame           (frame),
        .serializer_busy (serializer_busy),
        .sclk            (sclk),
        .sdo             (sdo)
    );

endmodule

/* tests/battleship_checks.svh */
// Included inside the testbench module after its errors counter and the package import
`ifndef BATTLESHIP_CHECKS_SVH
`define BATTLESHIP_CHECKS_SVH

// ------------------------------
// Compare tasks
// ------------------------------
task automatic check_result(input string name, input battleship_pkg::result_t expected,
                            input battleship_pkg::result_t actual);
    if (actual !== expected)
    begin
        $display("Fail at %0t: %s expected %0d got %0d", $time, name, expected, actual);
        errors++;
    end
endtask

task automatic check_frame(input string name,
                           input logic [battleship_pkg::FRAME_W-1:0] expected,
                           input logic [battleship_pkg::FRAME_W-1:0] actual);
    if (actual !== expected)
    begin
        $display("Fail at %0t: %s expected %h got %h", $time, name, expected, actual);
        errors++;
    end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected)
    begin
        $display("Fail at %0t: %s expected %b got %b", $time, name, expected, actual);
        errors++;
    end
endtask

// Receiver samples sdo on each rising sclk with the MSB first
task automatic capture_frame(output logic [battleship_pkg::FRAME_W-1:0] value);
    value = '0;
    for (int i = 0; i < battleship_pkg::FRAME_W; i++)
    begin
        @(posedge sclk);
        value = {value[battleship_pkg::FRAME_W-2:0], sdo};
    end
endtask

`endif

/* tests/battleship_tb.sv */
// Directed game run against a reference model that expects results to leave the DUT in move order
`timescale 1ns/1ps

module battleship_tb;
    import battleship_pkg::*;

    localparam int TOTAL_MOVES = 44;
    localparam int TIMEOUT_NS  = TOTAL_MOVES * 64 * 10 + 2000;

    logic               clk;
    logic               reset;
    logic               move_strobe;
    logic               player;
    logic               horizontal;
    logic [COORD_W-1:0] row;
    logic [COORD_W-1:0] col;
    logic               busy;
    logic               result_valid;
    logic               game_over;
    logic               sclk;
    logic               sdo;
    result_t            result;

    int                 errors;
    int                 moves_issued;
    int                 pulse_count;
    int unsigned        seed;

    // Reference model of both boards and fleets
    int                   lengths [NUM_SHIPS] = '{5, 4, 3, 3, 2};
    cell_state_t          mboard  [2][BOARD_SIZE][BOARD_SIZE];
    logic [SHIP_ID_W-1:0] mship   [2][BOARD_SIZE][BOARD_SIZE];
    int                   mplaced [2];
    int                   mleft   [2][NUM_SHIPS];
    int                   mafloat [2];
    logic                 mover;

    result_t            exp_results [$];
    result_t            got_results [$];
    logic [FRAME_W-1:0] exp_frames  [$];
    logic [FRAME_W-1:0] got_frames  [$];

    `include "battleship_checks.svh"

    battleship_top uut (
        .clk          (clk),
        .reset        (reset),
        .move_strobe  (move_strobe),
        .player       (player),
        .horizontal   (horizontal),
        .row          (row),
        .col          (col),
        .busy         (busy),
        .result_valid (result_valid),
        .game_over    (game_over),
        .sclk         (sclk),
        .sdo          (sdo),
        .result       (result)
    );

    always #5 clk = !clk;

    // ------------------------------
    // Reference model
    // ------------------------------
    task automatic model_move(input logic p, input logic h, input logic [3:0] r,
                              input logic [3:0] c);
        int                   opp;
        int                   len;
        logic                 bad;
        logic [SHIP_ID_W-1:0] ship;
        result_t              code;

        opp  = p ? 0 : 1;
        ship = '0;
        code = res_rejected;
        if (mover || r >= BOARD_SIZE || c >= BOARD_SIZE)
            code = res_rejected;
        else if (mplaced[0] < NUM_SHIPS || mplaced[1] < NUM_SHIPS)
        begin
            // A full fleet or a ship off the board is refused while placing
            if (mplaced[p] < NUM_SHIPS)
            begin
                len = lengths[mplaced[p]];
                bad = ((h ? c : r) + len > BOARD_SIZE);
                for (int k = 0; k < len && !bad; k++)
                    if (mboard[p][h ? r : r + k][h ? c + k : c] != cell_empty)
                        bad = 1'b1;
                if (!bad)
                begin
                    ship = mplaced[p];
                    for (int k = 0; k < len; k++)
                    begin
                        mboard[p][h ? r : r + k][h ? c + k : c] = cell_ship;
                        mship[p][h ? r : r + k][h ? c + k : c]  = ship;
                    end
                    mleft[p][ship] = len;
                    mplaced[p]     = mplaced[p] + 1;
                    mafloat[p]     = mafloat[p] + 1;
                    code           = res_placed;
                end
            end
        end
        else if (mboard[opp][r][c] == cell_empty)
        begin
            mboard[opp][r][c] = cell_miss;
            code              = res_miss;
        end
        else if (mboard[opp][r][c] == cell_ship)
        begin
            mboard[opp][r][c] = cell_hit;
            ship              = mship[opp][r][c];
            mleft[opp][ship]  = mleft[opp][ship] - 1;
            code              = res_hit;
            if (mleft[opp][ship] == 0)
            begin
                mafloat[opp] = mafloat[opp] - 1;
                code         = (mafloat[opp] == 0) ? res_win : res_sunk;
                mover        = (mafloat[opp] == 0);
            end
        end
        else
            code = res_repeat;
        exp_results.push_back(code);
        exp_frames.push_back({code, p, r, c, ship, mover});
    endtask

    task automatic init_model();
        for (int p = 0; p < 2; p++)
        begin
            mplaced[p] = 0;
            mafloat[p] = 0;
            for (int s = 0; s < NUM_SHIPS; s++)
                mleft[p][s] = 0;
            for (int r = 0; r < BOARD_SIZE; r++)
                for (int c = 0; c < BOARD_SIZE; c++)
                begin
                    mboard[p][r][c] = cell_empty;
                    mship[p][r][c]  = '0;
                end
        end
        mover = 1'b0;
    endtask

    // ------------------------------
    // Stimulus and monitors
    // ------------------------------
    // Called and returns 1 ns after a rising edge
    task automatic issue_move(input logic p, input logic h, input logic [3:0] r,
                              input logic [3:0] c);
        while (busy)
        begin
            @(posedge clk);
            #1;
        end
        move_strobe = 1'b1;
        player      = p;
        horizontal  = h;
        row         = r;
        col         = c;
        model_move(p, h, r, c);
        moves_issued++;
        @(posedge clk);
        #1;
        move_strobe = 1'b0;
    endtask

    task automatic shoot_line(input logic p, input logic h, input logic [3:0] r,
                              input logic [3:0] c, input int n);
        for (int k = 0; k < n; k++)
            issue_move(p, 1'b0, h ? r : r + k, h ? c + k : c);
    endtask

    // Random cell with nothing on it that was never shot
    task automatic pick_empty(input int b, output logic [3:0] r, output logic [3:0] c);
        r = $urandom % BOARD_SIZE;
        c = $urandom % BOARD_SIZE;
        while (mboard[b][r][c] != cell_empty)
        begin
            r = $urandom % BOARD_SIZE;
            c = $urandom % BOARD_SIZE;
        end
    endtask

    task automatic collect_results();
        forever
        begin
            @(negedge clk);
            if (result_valid)
            begin
                got_results.push_back(result);
                pulse_count++;
            end
        end
    endtask

    task automatic collect_frames();
        logic [FRAME_W-1:0] value;

        forever
        begin
            capture_frame(value);
            got_frames.push_back(value);
        end
    endtask

    // Waits for every queued result and frame, then compares them in order
    task automatic drain();
        result_t            er;
        result_t            ar;
        logic [FRAME_W-1:0] ef;
        logic [FRAME_W-1:0] af;

        while (got_results.size() < exp_results.size()
               || got_frames.size() < exp_frames.size())
            @(posedge clk);
        while (exp_results.size() > 0)
        begin
            er = exp_results.pop_front();
            ar = got_results.pop_front();
            check_result("result", er, ar);
        end
        while (exp_frames.size() > 0)
        begin
            ef = exp_frames.pop_front();
            af = got_frames.pop_front();
            check_frame("frame", ef, af);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic report_test(input string name, input int start_errors);
        if (errors == start_errors)
            $display("%0t %s: ok", $time, name);
        else
            $display("%0t %s: %0d errors", $time, name, errors - start_errors);
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic test_placements();
        int start;

        start = errors;
        issue_move(0, 1, 0, 0);
        issue_move(1, 0, 5, 0);
        issue_move(0, 0, 6, 9);
        issue_move(1, 1, 0, 6);
        issue_move(0, 1, 9, 0);
        issue_move(1, 0, 2, 3);
        drain();
        report_test("valid placements", start);
    endtask

    task automatic test_rejects();
        int start;

        start = errors;
        issue_move(0, 1, 3, 8);
        issue_move(0, 1, 10, 0);
        // Last cell lands on ship 2 in row 9
        issue_move(0, 0, 7, 1);
        issue_move(0, 0, 2, 5);
        issue_move(0, 1, 5, 8);
        issue_move(0, 1, 4, 0);
        // Player 1 still placing, so no shot can start
        issue_move(0, 0, 0, 6);
        issue_move(1, 1, 7, 4);
        issue_move(1, 0, 8, 9);
        drain();
        report_test("placement rejects", start);
    endtask

    task automatic test_shots();
        int         start;
        logic [3:0] mr;
        logic [3:0] mc;

        start = errors;
        pick_empty(1, mr, mc);
        issue_move(0, 0, mr, mc);
        issue_move(0, 0, 8, 9);
        issue_move(0, 0, mr, mc);
        issue_move(0, 0, 8, 9);
        issue_move(1, 0, 0, 0);
        drain();
        report_test("shots", start);
    endtask

    task automatic test_sinking();
        int start;

        start = errors;
        shoot_line(0, 0, 2, 3, 3);
        drain();
        report_test("sinking", start);
    endtask

    task automatic test_backpressure();
        int         start;
        logic [3:0] mr;
        logic [3:0] mc;

        start = errors;
        for (int i = 0; i < 6; i++)
        begin
            pick_empty(0, mr, mc);
            issue_move(1, 0, mr, mc);
        end
        drain();
        if (pulse_count != moves_issued)
        begin
            $display("Saw %0d result pulses for %0d moves", pulse_count, moves_issued);
            errors++;
        end
        report_test("back-pressure", start);
    endtask

    task automatic test_win();
        int start;

        start = errors;
        shoot_line(0, 1, 0, 6, 4);
        shoot_line(0, 0, 5, 0, 5);
        issue_move(0, 0, 9, 9);
        shoot_line(0, 1, 7, 4, 3);
        drain();
        check_bit("game_over", 1'b1, game_over);
        issue_move(1, 0, 0, 1);
        issue_move(0, 0, 6, 6);
        drain();
        check_bit("game_over", 1'b1, game_over);
        report_test("win", start);
    endtask

    initial
    begin
        #(TIMEOUT_NS);
        $display("Timeout: the DUT stopped producing results");
        $display("=== FAIL ===");
        $finish;
    end

    initial
    begin
        clk          = 1'b0;
        reset        = 1'b1;
        move_strobe  = 1'b0;
        player       = 1'b0;
        horizontal   = 1'b0;
        row          = '0;
        col          = '0;
        errors       = 0;
        moves_issued = 0;
        pulse_count  = 0;
        seed         = 14;
        void'($urandom(seed));
        init_model();
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        check_bit("busy", 1'b0, busy);
        check_bit("result_valid", 1'b0, result_valid);
        check_bit("game_over", 1'b0, game_over);
        check_bit("sclk", 1'b0, sclk);
        check_bit("sdo", 1'b0, sdo);
        fork
            collect_results();
            collect_frames();
        join_none
        test_placements();
        test_rejects();
        test_shots();
        test_sinking();
        test_backpressure();
        test_win();
        if (pulse_count != moves_issued)
        begin
            $display("Saw %0d result pulses for %0d moves", pulse_count, moves_issued);
            errors++;
        end
        $display("%0d moves, %0d results, %0d errors", moves_issued, pulse_count, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

/* battleship_top.f */
+incdir+tests
logic/battleship_pkg.sv
logic/result_serializer.sv
logic/fleet_tracker.sv
logic/board_engine.sv
logic/battleship_top.sv
tests/battleship_tb.sv

/* Bender.yml */
package:
  name: battleship

sources:
  - files:
      - logic/battleship_pkg.sv
      - logic/result_serializer.sv
      - logic/fleet_tracker.sv
      - logic/board_engine.sv
      - logic/battleship_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/battleship_tb.sv
